//--- verilog/dtm_pkg.sv
// shared constants, TAP state encoding and structs for the JTAG DTM
// every DTM module imports this package inside its body
`default_nettype none

package dtm_pkg;

    //----------------------------------------
    // instruction register
    //----------------------------------------
    localparam int ir_width = 5;

    localparam logic [ir_width-1:0] ir_idcode = 5'h01;
    localparam logic [ir_width-1:0] ir_dtmcs  = 5'h10;
    localparam logic [ir_width-1:0] ir_dmi    = 5'h11;
    localparam logic [ir_width-1:0] ir_bypass = 5'h1f;

    // loaded on Capture-IR and at reset, selects IDCODE
    localparam logic [ir_width-1:0] ir_capture_value = 5'h01;

    //----------------------------------------
    // debug module interface
    //----------------------------------------
    localparam int dmi_abits  = 7;
    localparam int dmi_data_w = 32;
    localparam int dmi_op_w   = 2;
    localparam int dmi_word_w = dmi_abits + dmi_data_w + dmi_op_w;

    // idle 5, dmistat 0, abits, version 1 (spec 0.13)
    localparam logic [31:0] dtmcs_value = {17'h0, 3'd5, 2'd0, 6'(dmi_abits), 4'd1};

    // addr sits in the msbs, op in the lsbs, same as the scan chain
    typedef struct packed {
        logic [dmi_abits-1:0]  addr;
        logic [dmi_data_w-1:0] data;
        logic [dmi_op_w-1:0]   op;
    } dmi_req_t;

    typedef struct packed {
        logic [dmi_abits-1:0]  addr;
        logic [dmi_data_w-1:0] data;
        logic [dmi_op_w-1:0]   op;
    } dmi_resp_t;

    //----------------------------------------
    // TAP controller
    //----------------------------------------
    // msb set for the IR half, except idle and reset
    typedef enum logic [3:0] {
        tap_exit2_dr   = 4'h0,
        tap_exit1_dr   = 4'h1,
        tap_shift_dr   = 4'h2,
        tap_pause_dr   = 4'h3,
        tap_select_ir  = 4'h4,
        tap_update_dr  = 4'h5,
        tap_capture_dr = 4'h6,
        tap_select_dr  = 4'h7,
        tap_exit2_ir   = 4'h8,
        tap_exit1_ir   = 4'h9,
        tap_shift_ir   = 4'ha,
        tap_pause_ir   = 4'hb,
        tap_idle       = 4'hc,
        tap_update_ir  = 4'hd,
        tap_capture_ir = 4'he,
        tap_reset      = 4'hf
    } tap_state_t;

    typedef struct packed {
        logic capture_ir;
        logic shift_ir;
        logic update_ir;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
        logic in_ir_scan;
        logic in_dr_scan;
    } tap_ctrl_t;

endpackage

`default_nettype wire

//--- verilog/jtag_tap_fsm.sv
// IEEE 1149.1 TAP state machine
// advances on TMS every rising TCK edge and decodes the state into strobes
`timescale 1ns/10ps
`default_nettype none

module jtag_tap_fsm (
    input  logic               dtm_tck,
    input  logic               dtm_rst_n,
    input  logic               tms,
    output dtm_pkg::tap_ctrl_t tap_ctrl
);
    import dtm_pkg::*;

    tap_state_t state;
    tap_state_t state_next;

    //----------------------------------------
    // state register
    //----------------------------------------
    always_ff @(posedge dtm_tck or negedge dtm_rst_n) begin
        if (!dtm_rst_n) begin
            state <= tap_reset;
        end else begin
            state <= state_next;
        end
    end

    // standard transitions, tms high first
    always_comb begin
        case (state)
            tap_reset:      state_next = tms ? tap_reset     : tap_idle;
            tap_idle:       state_next = tms ? tap_select_dr : tap_idle;

            // dr column
            tap_select_dr:  state_next = tms ? tap_select_ir : tap_capture_dr;
            tap_capture_dr: state_next = tms ? tap_exit1_dr  : tap_shift_dr;
            tap_shift_dr:   state_next = tms ? tap_exit1_dr  : tap_shift_dr;
            tap_exit1_dr:   state_next = tms ? tap_update_dr : tap_pause_dr;
            tap_pause_dr:   state_next = tms ? tap_exit2_dr  : tap_pause_dr;
            tap_exit2_dr:   state_next = tms ? tap_update_dr : tap_shift_dr;
            tap_update_dr:  state_next = tms ? tap_select_dr : tap_idle;

            // ir column
            tap_select_ir:  state_next = tms ? tap_reset     : tap_capture_ir;
            tap_capture_ir: state_next = tms ? tap_exit1_ir  : tap_shift_ir;
            tap_shift_ir:   state_next = tms ? tap_exit1_ir  : tap_shift_ir;
            tap_exit1_ir:   state_next = tms ? tap_update_ir : tap_pause_ir;
            tap_pause_ir:   state_next = tms ? tap_exit2_ir  : tap_pause_ir;
            tap_exit2_ir:   state_next = tms ? tap_update_ir : tap_shift_ir;
            tap_update_ir:  state_next = tms ? tap_select_dr : tap_idle;
            default:        state_next = tap_reset;
        endcase
    end

    //----------------------------------------
    // strobe decode
    //----------------------------------------
    always_comb begin
        tap_ctrl.capture_ir = (state == tap_capture_ir);
        tap_ctrl.shift_ir   = (state == tap_shift_ir);
        tap_ctrl.update_ir  = (state == tap_update_ir);
        tap_ctrl.capture_dr = (state == tap_capture_dr);
        tap_ctrl.shift_dr   = (state == tap_shift_dr);
        tap_ctrl.update_dr  = (state == tap_update_dr);

        // lower half is the dr column, except select-ir
        tap_ctrl.in_dr_scan = !state[3] && (state != tap_select_ir);

        // upper half is the ir column, except idle and reset
        tap_ctrl.in_ir_scan = (state[3] && (state != tap_idle) && (state != tap_reset))
                              || (state == tap_select_ir);
    end

endmodule

`default_nettype wire

//--- verilog/dtm_ir.sv
// instruction register with capture, shift and update hold
// tdo bit is launched on the falling TCK edge during Shift-IR
`timescale 1ns/10ps
`default_nettype none

module dtm_ir (
    input  logic                         dtm_tck,
    input  logic                         dtm_rst_n,
    input  logic                         tdi,
    input  dtm_pkg::tap_ctrl_t           tap_ctrl,
    output logic [dtm_pkg::ir_width-1:0] instruction,
    output logic                         ir_tdo
);
    import dtm_pkg::*;

    logic [ir_width-1:0] ir_shift;

    // scan copy, tdi enters at the msb
    always_ff @(posedge dtm_tck or negedge dtm_rst_n) begin
        if (!dtm_rst_n) begin
            ir_shift <= ir_capture_value;
        end else if (tap_ctrl.capture_ir) begin
            ir_shift <= ir_capture_value;
        end else if (tap_ctrl.shift_ir) begin
            ir_shift <= {tdi, ir_shift[ir_width-1:1]};
        end
    end

    // active instruction, held from update-ir
    always_ff @(posedge dtm_tck or negedge dtm_rst_n) begin
        if (!dtm_rst_n) begin
            instruction <= ir_capture_value;
        end else if (tap_ctrl.update_ir) begin
            instruction <= ir_shift;
        end
    end

    always_ff @(negedge dtm_tck or negedge dtm_rst_n) begin
        if (!dtm_rst_n) begin
            ir_tdo <= 1'b0;
        end else begin
            ir_tdo <= tap_ctrl.shift_ir ? ir_shift[0] : 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dtm_dr_chain.sv
// data registers of the DTM: IDCODE, DTMCS, DMI access and BYPASS
// captures and shifts the register picked by the instruction, pulses dmi_update
`timescale 1ns/10ps
`default_nettype none

module dtm_dr_chain #(
    parameter logic [31:0] idcode_value = 32'habcd_beaf
) (
    input  logic                         dtm_tck,
    input  logic                         dtm_rst_n,
    input  logic                         tdi,
    input  dtm_pkg::tap_ctrl_t           tap_ctrl,
    input  logic [dtm_pkg::ir_width-1:0] instruction,
    input  dtm_pkg::dmi_resp_t           dmi_last_resp,
    output dtm_pkg::dmi_req_t            dmi_word,
    output logic                         dmi_update,
    output logic                         dr_tdo
);
    import dtm_pkg::*;

    logic [31:0]           idcode_r;
    logic [31:0]           dtmcs_r;
    logic [dmi_word_w-1:0] dmi_r;
    logic                  bypass_r;

    logic sel_idcode;
    logic sel_dtmcs;
    logic sel_dmi;
    logic sel_bypass;
    logic dr_bit0;

    //----------------------------------------
    // register select
    //----------------------------------------
    // unknown codes fall back to bypass
    always_comb begin
        sel_idcode = 1'b0;
        sel_dtmcs  = 1'b0;
        sel_dmi    = 1'b0;
        sel_bypass = 1'b0;
        case (instruction)
            ir_idcode: sel_idcode = 1'b1;
            ir_dtmcs:  sel_dtmcs  = 1'b1;
            ir_dmi:    sel_dmi    = 1'b1;
            ir_bypass: sel_bypass = 1'b1;
            default:   sel_bypass = 1'b1;
        endcase
    end

    //----------------------------------------
    // capture and shift
    //----------------------------------------
    always_ff @(posedge dtm_tck or negedge dtm_rst_n) begin
        if (!dtm_rst_n) begin
            idcode_r <= idcode_value;
            dtmcs_r  <= dtmcs_value;
            dmi_r    <= '0;
            bypass_r <= 1'b0;
        end else if (tap_ctrl.capture_dr) begin
            // bypass keeps its bit on capture
            if (sel_idcode) begin
                idcode_r <= idcode_value;
            end
            if (sel_dtmcs) begin
                dtmcs_r <= dtmcs_value;
            end
            if (sel_dmi) begin
                dmi_r <= dmi_last_resp;
            end
        end else if (tap_ctrl.shift_dr) begin
            if (sel_idcode) begin
                idcode_r <= {tdi, idcode_r[31:1]};
            end
            if (sel_dtmcs) begin
                dtmcs_r <= {tdi, dtmcs_r[31:1]};
            end
            if (sel_dmi) begin
                dmi_r <= {tdi, dmi_r[dmi_word_w-1:1]};
            end
            if (sel_bypass) begin
                bypass_r <= tdi;
            end
        end
    end

    //----------------------------------------
    // serial out and dmi hand-off
    //----------------------------------------
    assign dr_bit0 = (sel_idcode & idcode_r[0])
                   | (sel_dtmcs  & dtmcs_r[0])
                   | (sel_dmi    & dmi_r[0])
                   | (sel_bypass & bypass_r);

    always_ff @(negedge dtm_tck or negedge dtm_rst_n) begin
        if (!dtm_rst_n) begin
            dr_tdo <= 1'b0;
        end else begin
            dr_tdo <= tap_ctrl.shift_dr ? dr_bit0 : 1'b0;
        end
    end

    // one cycle, the TAP stays in update-dr for one edge only
    assign dmi_update = tap_ctrl.update_dr && sel_dmi;
    assign dmi_word   = dmi_r;

endmodule

`default_nettype wire

//--- verilog/dmi_master.sv
// DMI request/response master towards the debug module
// issues one valid/ready request per accepted update, keeps the reply for capture
`timescale 1ns/10ps
`default_nettype none

module dmi_master (
    input  logic               dtm_tck,
    input  logic               dtm_rst_n,
    input  logic               dmi_update,
    input  dtm_pkg::dmi_req_t  dmi_word,
    output logic               dmi_req_vld,
    input  logic               dmi_req_rdy,
    output dtm_pkg::dmi_req_t  dmi_req,
    input  logic               dmi_resp_vld,
    output logic               dmi_resp_rdy,
    input  dtm_pkg::dmi_resp_t dmi_resp,
    output dtm_pkg::dmi_resp_t dmi_last_resp
);
    import dtm_pkg::*;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_req  = 2'd1,
        st_ack  = 2'd2
    } dmi_state_t;

    dmi_state_t state;
    dmi_state_t state_next;
    dmi_req_t   req_r;
    logic       req_fire;
    logic       resp_fire;

    assign req_fire  = dmi_req_vld && dmi_req_rdy;
    assign resp_fire = dmi_resp_vld && dmi_resp_rdy;

    //----------------------------------------
    // request FSM
    //----------------------------------------
    // updates outside idle are dropped
    always_comb begin
        state_next = state;
        case (state)
            st_idle: state_next = dmi_update ? st_req  : st_idle;
            st_req:  state_next = req_fire   ? st_ack  : st_req;
            st_ack:  state_next = resp_fire  ? st_idle : st_ack;
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge dtm_tck or negedge dtm_rst_n) begin
        if (!dtm_rst_n) begin
            state         <= st_idle;
            dmi_last_resp <= '0;
        end else begin
            state <= state_next;
            if (state == st_ack && resp_fire) begin
                dmi_last_resp <= dmi_resp;
            end
        end
    end

    // request word frozen at the update edge
    always_ff @(posedge dtm_tck) begin
        if (state == st_idle && dmi_update) begin
            req_r <= dmi_word;
        end
    end

    assign dmi_req_vld  = (state == st_req);
    assign dmi_req      = req_r;
    assign dmi_resp_rdy = 1'b1;

endmodule

`default_nettype wire

//--- verilog/dtm_top.sv
// top level of the JTAG debug transport module
// ties TAP, IR, DR chain and DMI master together and selects TDO
`timescale 1ns/10ps
`default_nettype none

module dtm_top #(
    parameter logic [31:0] idcode_value = 32'habcd_beaf
) (
    input  logic               dtm_tck,
    input  logic               dtm_rst_n,
    input  logic               dtm_tms,
    input  logic               dtm_tdi,
    output logic               dtm_tdo,
    output logic               dtm_tdo_vld,
    output logic               dmi_req_vld,
    input  logic               dmi_req_rdy,
    output dtm_pkg::dmi_req_t  dmi_req,
    input  logic               dmi_resp_vld,
    output logic               dmi_resp_rdy,
    input  dtm_pkg::dmi_resp_t dmi_resp
);
    import dtm_pkg::*;

    tap_ctrl_t           tap_ctrl;
    logic [ir_width-1:0] instruction;
    logic                ir_tdo;
    logic                dr_tdo;
    logic                dmi_update;
    dmi_req_t            dmi_word;
    dmi_resp_t           dmi_last_resp;

    jtag_tap_fsm u_tap (
        .dtm_tck   (dtm_tck),
        .dtm_rst_n (dtm_rst_n),
        .tms       (dtm_tms),
        .tap_ctrl  (tap_ctrl)
    );

    dtm_ir u_ir (
        .dtm_tck     (dtm_tck),
        .dtm_rst_n   (dtm_rst_n),
        .tdi         (dtm_tdi),
        .tap_ctrl    (tap_ctrl),
        .instruction (instruction),
        .ir_tdo      (ir_tdo)
    );

    dtm_dr_chain #(
        .idcode_value (idcode_value)
    ) u_dr_chain (
        .dtm_tck       (dtm_tck),
        .dtm_rst_n     (dtm_rst_n),
        .tdi           (dtm_tdi),
        .tap_ctrl      (tap_ctrl),
        .instruction   (instruction),
        .dmi_last_resp (dmi_last_resp),
        .dmi_word      (dmi_word),
        .dmi_update    (dmi_update),
        .dr_tdo        (dr_tdo)
    );

    dmi_master u_dmi_master (
        .dtm_tck       (dtm_tck),
        .dtm_rst_n     (dtm_rst_n),
        .dmi_update    (dmi_update),
        .dmi_word      (dmi_word),
        .dmi_req_vld   (dmi_req_vld),
        .dmi_req_rdy   (dmi_req_rdy),
        .dmi_req       (dmi_req),
        .dmi_resp_vld  (dmi_resp_vld),
        .dmi_resp_rdy  (dmi_resp_rdy),
        .dmi_resp      (dmi_resp),
        .dmi_last_resp (dmi_last_resp)
    );

    //----------------------------------------
    // tdo select
    //----------------------------------------
    assign dtm_tdo     = tap_ctrl.in_ir_scan ? ir_tdo :
                         (tap_ctrl.in_dr_scan ? dr_tdo : 1'b0);
    assign dtm_tdo_vld = tap_ctrl.shift_ir || tap_ctrl.shift_dr;

endmodule

`default_nettype wire

//--- testbench/tb_dtm.sv
// testbench for the JTAG debug transport module
// drives directed TAP scans and models the debug module on the DMI side
// the run ends with one count line and a pass or fail line
`timescale 1ns/10ps
`default_nettype none

module tb_dtm;
    import dtm_pkg::*;

    localparam logic [31:0] tb_idcode = 32'h1e5a_93c7;
    // roughly 500 cycles of scans and DMI waits, limit leaves wide margin
    localparam int max_cycles = 4000;

    logic      dtm_tck;
    logic      dtm_rst_n;
    logic      dtm_tms;
    logic      dtm_tdi;
    logic      dtm_tdo;
    logic      dtm_tdo_vld;
    logic      dmi_req_vld;
    logic      dmi_req_rdy  = 1'b0;
    dmi_req_t  dmi_req;
    logic      dmi_resp_vld = 1'b0;
    logic      dmi_resp_rdy;
    dmi_resp_t dmi_resp     = '0;

    // debug module model state
    logic        hold_ready;
    logic [15:0] stim_lfsr   = 16'd37;
    logic [15:0] resp_lfsr   = 16'd37;
    logic [63:0] resp_bits;
    dmi_req_t    last_req    = '0;
    dmi_req_t    pending_req = '0;
    logic        req_pending = 1'b0;
    logic        stall_set   = 1'b0;
    int          stall       = 0;
    int          resp_wait   = 0;
    int          req_count   = 0;
    int          resp_count  = 0;

    int check_count = 0;
    int error_count = 0;
    int cycle_count = 0;

    dtm_top #(
        .idcode_value (tb_idcode)
    ) UUT (
        .dtm_tck      (dtm_tck),
        .dtm_rst_n    (dtm_rst_n),
        .dtm_tms      (dtm_tms),
        .dtm_tdi      (dtm_tdi),
        .dtm_tdo      (dtm_tdo),
        .dtm_tdo_vld  (dtm_tdo_vld),
        .dmi_req_vld  (dmi_req_vld),
        .dmi_req_rdy  (dmi_req_rdy),
        .dmi_req      (dmi_req),
        .dmi_resp_vld (dmi_resp_vld),
        .dmi_resp_rdy (dmi_resp_rdy),
        .dmi_resp     (dmi_resp)
    );

    initial begin
        dtm_tck = 1'b0;
        forever #50 dtm_tck = ~dtm_tck;
    end

    //----------------------------------------
    // helpers
    //----------------------------------------
    // galois feedback with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(inout logic [15:0] st, input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = st[0];
            st = lfsr_next(st);
        end
    endtask

    // model answer: same addr and op, data inverted
    function automatic logic [63:0] expected_resp(input logic [63:0] w);
        return {23'd0, w[40:34], ~w[33:2], w[1:0]};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_quiet(input logic tdo_s, input logic vld_s);
        check_value("dtm_tdo", 64'(tdo_s), 64'd0);
        check_value("dtm_tdo_vld", 64'(vld_s), 64'd0);
    endtask

    // one TCK period, outputs sampled before the edge updates the TAP
    task automatic tck_cycle(input logic tms_v, input logic tdi_v,
                             output logic tdo_s, output logic vld_s);
        dtm_tms <= tms_v;
        dtm_tdi <= tdi_v;
        @(posedge dtm_tck);
        tdo_s = dtm_tdo;
        vld_s = dtm_tdo_vld;
    endtask

    task automatic tap_go_idle();
        logic tdo_s;
        logic vld_s;
        tck_cycle(1'b0, 1'b0, tdo_s, vld_s);
        check_quiet(tdo_s, vld_s);
    endtask

    task automatic tap_reset_tms();
        logic tdo_s;
        logic vld_s;
        repeat (5) tck_cycle(1'b1, 1'b0, tdo_s, vld_s);
        tap_go_idle();
    endtask

    // idle to idle scan, tdo bits come back lsb first
    task automatic jtag_scan(input logic is_ir, input int len, input logic [63:0] din,
                             output logic [63:0] dout);
        logic tdo_s;
        logic vld_s;
        dout = '0;
        tck_cycle(1'b1, 1'b0, tdo_s, vld_s);
        check_quiet(tdo_s, vld_s);
        if (is_ir) begin
            tck_cycle(1'b1, 1'b0, tdo_s, vld_s);
            check_quiet(tdo_s, vld_s);
        end
        // select, then capture
        tck_cycle(1'b0, 1'b0, tdo_s, vld_s);
        check_quiet(tdo_s, vld_s);
        tck_cycle(1'b0, 1'b0, tdo_s, vld_s);
        check_quiet(tdo_s, vld_s);
        for (int i = 0; i < len; i++) begin
            tck_cycle(i == len - 1, din[i], tdo_s, vld_s);
            dout[i] = tdo_s;
            check_value("dtm_tdo_vld", 64'(vld_s), 64'd1);
        end
        // exit1, then update
        tck_cycle(1'b1, 1'b0, tdo_s, vld_s);
        check_quiet(tdo_s, vld_s);
        tck_cycle(1'b0, 1'b0, tdo_s, vld_s);
        check_quiet(tdo_s, vld_s);
    endtask

    task automatic wait_responses(input int target);
        while (resp_count < target) begin
            @(posedge dtm_tck);
        end
    endtask

    task automatic report_and_finish();
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    //----------------------------------------
    // debug module responder
    //----------------------------------------
    always @(posedge dtm_tck) begin
        // a waiting request must not move
        if (req_pending) begin
            check_value("dmi_req_vld", 64'(dmi_req_vld), 64'd1);
            check_value("dmi_req", 64'(dmi_req), 64'(pending_req));
        end
        req_pending = dmi_req_vld && !dmi_req_rdy;
        pending_req = dmi_req;

        if (dmi_resp_vld) begin
            check_value("dmi_resp_rdy", 64'(dmi_resp_rdy), 64'd1);
            dmi_resp_vld <= 1'b0;
            resp_count   <= resp_count + 1;
        end
        if (resp_wait > 0) begin
            resp_wait = resp_wait - 1;
            if (resp_wait == 0) begin
                dmi_resp_vld  <= 1'b1;
                dmi_resp.addr <= last_req.addr;
                dmi_resp.data <= ~last_req.data;
                dmi_resp.op   <= last_req.op;
            end
        end

        if (dmi_req_vld && dmi_req_rdy) begin
            dmi_req_rdy <= 1'b0;
            last_req    <= dmi_req;
            req_count   <= req_count + 1;
            draw_bits(resp_lfsr, 2, resp_bits);
            resp_wait = 1 + int'(resp_bits[1:0]);
            stall_set = 1'b0;
        end else if (dmi_req_vld && !hold_ready) begin
            if (!stall_set) begin
                draw_bits(resp_lfsr, 2, resp_bits);
                stall     = int'(resp_bits[1:0]);
                stall_set = 1'b1;
            end
            if (stall == 0) begin
                dmi_req_rdy <= 1'b1;
            end else begin
                stall = stall - 1;
            end
        end
    end

    //----------------------------------------
    // directed tests
    //----------------------------------------
    task automatic idcode_after_reset();
        logic [63:0] din;
        logic [63:0] dout;
        tap_go_idle();
        draw_bits(stim_lfsr, 32, din);
        jtag_scan(1'b0, 32, din, dout);
        check_value("idcode", dout, 64'(tb_idcode));
    endtask

    task automatic ir_capture_and_dtmcs();
        logic [63:0] din;
        logic [63:0] dout;
        tap_reset_tms();
        jtag_scan(1'b1, 5, 64'(ir_dtmcs), dout);
        check_value("ir capture", dout, 64'h01);
        // idle 5, abits 7, version 1
        repeat (2) begin
            draw_bits(stim_lfsr, 32, din);
            jtag_scan(1'b0, 32, din, dout);
            check_value("dtmcs", dout, 64'h5071);
        end
    endtask

    task automatic bypass_delay(input logic [ir_width-1:0] code);
        logic [63:0] pat;
        logic [63:0] dout;
        jtag_scan(1'b1, 5, 64'(code), dout);
        draw_bits(stim_lfsr, 16, pat);
        jtag_scan(1'b0, 17, pat, dout);
        check_value("bypass out", 64'(dout[16:1]), 64'(pat[15:0]));
    endtask

    task automatic dmi_single_access();
        logic [63:0] word;
        logic [63:0] dout;
        int          base_req;
        int          base_resp;
        base_req  = req_count;
        base_resp = resp_count;
        jtag_scan(1'b1, 5, 64'(ir_dmi), dout);
        draw_bits(stim_lfsr, 41, word);
        jtag_scan(1'b0, 41, word, dout);
        wait_responses(base_resp + 1);
        check_value("dmi request count", 64'(req_count - base_req), 64'd1);
        check_value("dmi_req.addr", 64'(last_req.addr), 64'(word[40:34]));
        check_value("dmi_req.data", 64'(last_req.data), 64'(word[33:2]));
        check_value("dmi_req.op", 64'(last_req.op), 64'(word[1:0]));
        jtag_scan(1'b0, 41, 64'd0, dout);
        check_value("dmi readback", dout, expected_resp(word));
        wait_responses(base_resp + 2);
    endtask

    task automatic dmi_backpressure();
        logic [63:0] word1;
        logic [63:0] word2;
        logic [63:0] dout;
        int          base_req;
        int          base_resp;
        base_req  = req_count;
        base_resp = resp_count;
        draw_bits(stim_lfsr, 41, word1);
        draw_bits(stim_lfsr, 41, word2);
        hold_ready <= 1'b1;
        jtag_scan(1'b0, 41, word1, dout);
        while (!dmi_req_vld) begin
            @(posedge dtm_tck);
        end
        repeat (6) begin
            @(posedge dtm_tck);
            check_value("dmi_req_vld", 64'(dmi_req_vld), 64'd1);
            check_value("dmi_req", 64'(dmi_req), word1);
        end
        // second update lands while the first request still waits
        jtag_scan(1'b0, 41, word2, dout);
        hold_ready <= 1'b0;
        wait_responses(base_resp + 1);
        repeat (8) begin
            @(posedge dtm_tck);
            check_value("dmi_req_vld", 64'(dmi_req_vld), 64'd0);
        end
        check_value("dmi request count", 64'(req_count - base_req), 64'd1);
        jtag_scan(1'b0, 41, 64'd0, dout);
        check_value("dmi readback", dout, expected_resp(word1));
        wait_responses(base_resp + 2);
    endtask

    //----------------------------------------
    // main sequence and timeout
    //----------------------------------------
    initial begin
        dtm_rst_n  = 1'b0;
        dtm_tms    = 1'b1;
        dtm_tdi    = 1'b0;
        hold_ready = 1'b0;
        repeat (4) @(posedge dtm_tck);
        dtm_rst_n <= 1'b1;
        idcode_after_reset();
        ir_capture_and_dtmcs();
        bypass_delay(ir_bypass);
        bypass_delay(5'h12);
        dmi_single_access();
        dmi_backpressure();
        report_and_finish();
    end

    initial begin
        while (cycle_count < max_cycles) begin
            @(posedge dtm_tck);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", max_cycles);
        error_count++;
        report_and_finish();
    end

endmodule

`default_nettype wire

//--- all.f
verilog/dtm_pkg.sv
verilog/jtag_tap_fsm.sv
verilog/dtm_ir.sv
verilog/dtm_dr_chain.sv
verilog/dmi_master.sv
verilog/dtm_top.sv
testbench/tb_dtm.sv

//--- run_sim.sh
#!/bin/sh
# build the DTM testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module tb_dtm -o tb_dtm
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_dtm > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
